// ==== all.f ====
+incdir+design
design/cop_isa_pkg.sv
design/cop_check_pkg.sv
design/cop_decode.sv
design/cop_execute.sv
design/cop_result.sv
design/cop_grm.sv
design/cop_lockstep_check.sv
design/cop_lockstep_top.sv
tests/tb_cop_lockstep.sv

// ==== design/cop_check_pkg.sv ====
package cop_check_pkg;

    // Lockstep mismatch classes, highest priority first after FLT_NONE
    typedef enum logic [2:0] {
        FLT_NONE    = 3'd0,  // Pair agrees
        FLT_VALID   = 3'd1,  // One side valid, other not
        FLT_RESULT  = 3'd2,  // Result codes differ
        FLT_WEN     = 3'd3,  // Write enables differ
        FLT_RD_ADDR = 3'd4,  // Destination differs on a write
        FLT_RD_DATA = 3'd5,  // Write data differs
        FLT_TXCOUNT = 3'd6   // More in flight than the pipe can hold
    } cop_fault_t;

endpackage

// ==== design/cop_decode.sv ====
`timescale 1ns/100ps
`include "cop_params.svh"

module cop_decode (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    input  logic                         in_valid,    // Instruction offered
    input  logic [31:0]                  insn_enc,
    input  logic [`COP_XLEN-1:0]         rs1,         // GPR value from host
    output logic                         dec_valid,
    output cop_isa_pkg::cop_op_t         dec_op,
    output cop_isa_pkg::cop_result_t     dec_result,
    output logic [cop_isa_pkg::SHAMT_W-1:0] dec_shamt,
    output logic [`COP_RADDR_W-1:0]      dec_rd,
    output logic [`COP_XLEN-1:0]         dec_rs1
);

    import cop_isa_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    cop_op_t     op_d;
    cop_result_t res_d;

    assign opcode = insn_enc[6:0];
    assign funct3 = insn_enc[FLD_F3_LSB +: 3];
    assign funct7 = insn_enc[FLD_F7_LSB +: 7];

    // Legality first, then funct3 picks the op
    always_comb begin
        if (opcode != COP_OPCODE) begin
            op_d  = OP_NONE;
            res_d = RES_BAD_OPCODE;
        end else if (funct7 != 7'd0 || funct3 == 3'd7) begin
            op_d  = OP_NONE;
            res_d = RES_BAD_FUNCT;
        end else begin
            op_d  = cop_op_t'(funct3);  // Enum order follows funct3
            res_d = RES_OK;
        end
    end

    always_ff @(posedge g_clk) begin
        if (g_resetn) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // Payload only moves when something arrives
    always_ff @(posedge g_clk) begin
        if (in_valid) begin
            dec_op     <= op_d;
            dec_result <= res_d;
            dec_shamt  <= insn_enc[FLD_SHAMT_LSB +: SHAMT_W];
            dec_rd     <= insn_enc[FLD_RD_LSB +: `COP_RADDR_W];
            dec_rs1    <= rs1;
        end
    end

endmodule

// ==== design/cop_execute.sv ====
`timescale 1ns/100ps
`include "cop_params.svh"

module cop_execute (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    input  logic                         dec_valid,
    input  cop_isa_pkg::cop_op_t         dec_op,
    input  cop_isa_pkg::cop_result_t     dec_result,
    input  logic [cop_isa_pkg::SHAMT_W-1:0] dec_shamt,
    input  logic [`COP_RADDR_W-1:0]      dec_rd,
    input  logic [`COP_XLEN-1:0]         dec_rs1,
    output logic                         ex_valid,
    output cop_isa_pkg::cop_result_t     ex_result,
    output logic [`COP_RADDR_W-1:0]      ex_rd,
    output logic [`COP_XLEN-1:0]         ex_data
);

    import cop_isa_pkg::*;

    logic [`COP_XLEN-1:0] ex_d;  // Next value for ex_data

    // ------------------------------------------------------------------
    // Functional units, one per op

    always_comb begin
        case (dec_op)
            OP_ROR:   ex_d = cop_ror(dec_rs1, dec_shamt);
            OP_REV8:  ex_d = cop_rev8(dec_rs1);
            OP_BREV8: ex_d = cop_brev8(dec_rs1);
            OP_SIG0:  ex_d = cop_sig0(dec_rs1);   // SHA-256 message schedule
            OP_SIG1:  ex_d = cop_sig1(dec_rs1);
            OP_SUM0:  ex_d = cop_sum0(dec_rs1);   // SHA-256 compression
            OP_SUM1:  ex_d = cop_sum1(dec_rs1);
            default:  ex_d = '0;                  // OP_NONE
        endcase
    end

    // ------------------------------------------------------------------
    // Stage register

    always_ff @(posedge g_clk) begin
        if (g_resetn) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (dec_valid) begin
            ex_result <= dec_result;  // Carried through untouched
            ex_rd     <= dec_rd;
            ex_data   <= ex_d;
        end
    end

endmodule

// ==== design/cop_grm.sv ====
`timescale 1ns/100ps
`include "cop_params.svh"

module cop_grm (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      in_valid,
    input  logic [31:0]               insn_enc,
    input  logic [`COP_XLEN-1:0]      rs1,
    output logic                      grm_out_valid,
    output cop_isa_pkg::cop_result_t  grm_result,
    output logic                      grm_rd_wen,
    output logic [`COP_RADDR_W-1:0]   grm_rd_addr,
    output logic [`COP_XLEN-1:0]      grm_rd_data
);

    import cop_isa_pkg::*;

    localparam int unsigned D = `COP_PIPE_DEPTH;

    cop_result_t              res_c;
    logic                     wen_c;
    logic [`COP_XLEN-1:0]     data_c;

    logic                     v_q    [D];   // Delay line, [0] is youngest
    cop_result_t              res_q  [D];
    logic                     wen_q  [D];
    logic [`COP_RADDR_W-1:0]  addr_q [D];
    logic [`COP_XLEN-1:0]     data_q [D];

    // ------------------------------------------------------------------
    // Whole instruction in one pass, rotates as windows of {rs1, rs1}

    always_comb begin : grm_eval
        logic [2*`COP_XLEN-1:0] dbl;
        logic [`COP_XLEN-1:0]   val;
        int unsigned            sh;
        dbl = {rs1, rs1};
        sh  = insn_enc[FLD_SHAMT_LSB +: SHAMT_W];
        val = '0;
        if (insn_enc[6:0] != COP_OPCODE) begin
            res_c = RES_BAD_OPCODE;
        end else if (insn_enc[31:25] != 7'd0 || insn_enc[14:12] == 3'b111) begin
            res_c = RES_BAD_FUNCT;
        end else begin
            res_c = RES_OK;
            case (insn_enc[FLD_F3_LSB +: 3])
                3'd0: val = dbl[sh +: `COP_XLEN];
                3'd1: begin
                    for (int i = 0; i < `COP_XLEN; i++) begin
                        val[i] = rs1[(`COP_XLEN - 8 - (i & ~7)) + (i & 7)];  // Byte swap
                    end
                end
                3'd2: begin
                    for (int i = 0; i < `COP_XLEN; i++) begin
                        val[i] = rs1[(i & ~7) + (7 - (i & 7))];  // Mirror in byte
                    end
                end
                3'd3: val = dbl[7 +: `COP_XLEN] ^ dbl[18 +: `COP_XLEN] ^ (rs1 >> 3);
                3'd4: val = dbl[17 +: `COP_XLEN] ^ dbl[19 +: `COP_XLEN] ^ (rs1 >> 10);
                3'd5: val = dbl[2 +: `COP_XLEN] ^ dbl[13 +: `COP_XLEN] ^ dbl[22 +: `COP_XLEN];
                default: val = dbl[6 +: `COP_XLEN] ^ dbl[11 +: `COP_XLEN] ^ dbl[25 +: `COP_XLEN];
            endcase
        end
        wen_c  = (res_c == RES_OK) && (insn_enc[11:7] != 5'd0);
        data_c = wen_c ? val : '0;
    end

    // ------------------------------------------------------------------
    // Align with the DUT pipeline

    always_ff @(posedge g_clk) begin
        if (g_resetn) begin
            for (int i = 0; i < D; i++) begin
                v_q[i]   <= 1'b0;
                wen_q[i] <= 1'b0;
            end
        end else begin
            v_q[0]   <= in_valid;
            wen_q[0] <= in_valid && wen_c;
            for (int i = 1; i < D; i++) begin
                v_q[i]   <= v_q[i-1];
                wen_q[i] <= wen_q[i-1];
            end
        end
    end

    always_ff @(posedge g_clk) begin
        res_q[0]  <= res_c;
        addr_q[0] <= insn_enc[FLD_RD_LSB +: `COP_RADDR_W];
        data_q[0] <= data_c;
        for (int i = 1; i < D; i++) begin
            res_q[i]  <= res_q[i-1];
            addr_q[i] <= addr_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    assign grm_out_valid = v_q[D-1];
    assign grm_result    = res_q[D-1];
    assign grm_rd_wen    = wen_q[D-1];
    assign grm_rd_addr   = addr_q[D-1];
    assign grm_rd_data   = data_q[D-1];

endmodule

// ==== design/cop_isa_pkg.sv ====
`include "cop_params.svh"

package cop_isa_pkg;

    // ------------------------------------------------------------------
    // Instruction encoding

    localparam logic [6:0]  COP_OPCODE    = 7'b0001011;  // custom-0 major opcode
    localparam int unsigned FLD_RD_LSB    = 7;           // rd in [11:7]
    localparam int unsigned FLD_F3_LSB    = 12;          // funct3 in [14:12]
    localparam int unsigned FLD_SHAMT_LSB = 20;          // shamt in [24:20]
    localparam int unsigned FLD_F7_LSB    = 25;          // funct7 in [31:25]
    localparam int unsigned SHAMT_W       = $clog2(`COP_XLEN);

    // rs1 index sits in [19:15] and is never looked at here
    // The host reads the GPR and hands over the value

    typedef enum logic [2:0] {
        OP_ROR   = 3'd0,  // Rotate right by shamt
        OP_REV8  = 3'd1,  // Byte reverse
        OP_BREV8 = 3'd2,  // Bit reverse inside each byte
        OP_SIG0  = 3'd3,
        OP_SIG1  = 3'd4,
        OP_SUM0  = 3'd5,
        OP_SUM1  = 3'd6,
        OP_NONE  = 3'd7   // Illegal, yields zero
    } cop_op_t;

    typedef enum logic [2:0] {
        RES_OK         = 3'd0,
        RES_BAD_OPCODE = 3'd1,
        RES_BAD_FUNCT  = 3'd2  // funct7 nonzero or funct3 of 7
    } cop_result_t;

    typedef logic [`COP_XLEN-1:0] cop_word_t;

    // ------------------------------------------------------------------
    // Bit manipulation and SHA-256 helpers

    function automatic cop_word_t cop_ror(input cop_word_t x, input logic [SHAMT_W-1:0] n);
        return (x >> n) | (x << (`COP_XLEN - n));  // n of 0 shifts the left part out
    endfunction

    function automatic cop_word_t cop_rev8(input cop_word_t x);
        cop_word_t r;
        for (int b = 0; b < `COP_XLEN / 8; b++) begin
            r[8*b +: 8] = x[`COP_XLEN - 8*(b+1) +: 8];
        end
        return r;
    endfunction

    function automatic cop_word_t cop_brev8(input cop_word_t x);
        cop_word_t r;
        for (int b = 0; b < `COP_XLEN / 8; b++) begin
            r[8*b +: 8] = {<<{x[8*b +: 8]}};  // Mirror one byte
        end
        return r;
    endfunction

    function automatic cop_word_t cop_sig0(input cop_word_t x);
        return cop_ror(x, 7) ^ cop_ror(x, 18) ^ (x >> 3);
    endfunction

    function automatic cop_word_t cop_sig1(input cop_word_t x);
        return cop_ror(x, 17) ^ cop_ror(x, 19) ^ (x >> 10);
    endfunction

    function automatic cop_word_t cop_sum0(input cop_word_t x);
        return cop_ror(x, 2) ^ cop_ror(x, 13) ^ cop_ror(x, 22);
    endfunction

    function automatic cop_word_t cop_sum1(input cop_word_t x);
        return cop_ror(x, 6) ^ cop_ror(x, 11) ^ cop_ror(x, 25);
    endfunction

endpackage

// ==== design/cop_lockstep_check.sv ====
`timescale 1ns/100ps
`include "cop_params.svh"

module cop_lockstep_check (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic                       dut_in_valid,
    input  logic                       dut_out_valid,
    input  cop_isa_pkg::cop_result_t   dut_result,
    input  logic                       dut_rd_wen,
    input  logic [`COP_RADDR_W-1:0]    dut_rd_addr,
    input  logic [`COP_XLEN-1:0]       dut_rd_data,
    input  logic                       grm_out_valid,
    input  cop_isa_pkg::cop_result_t   grm_result,
    input  logic                       grm_rd_wen,
    input  logic [`COP_RADDR_W-1:0]    grm_rd_addr,
    input  logic [`COP_XLEN-1:0]       grm_rd_data,
    output logic                       fault,       // Sticky until reset
    output cop_check_pkg::cop_fault_t  fault_code   // First fault seen
);

    import cop_isa_pkg::*;
    import cop_check_pkg::*;

    logic [`COP_TXCNT_W-1:0] tx_i_cnt;
    logic [`COP_TXCNT_W-1:0] tx_o_cnt;
    logic [`COP_TXCNT_W-1:0] n_tx_i_cnt;
    logic [`COP_TXCNT_W-1:0] n_tx_o_cnt;
    logic [`COP_TXCNT_W-1:0] outstanding;  // Wraps cleanly with the counters
    cop_fault_t              flt_now;

    // ------------------------------------------------------------------
    // Transaction accounting

    assign n_tx_i_cnt  = tx_i_cnt + dut_in_valid;
    assign n_tx_o_cnt  = tx_o_cnt + dut_out_valid;
    assign outstanding = n_tx_i_cnt - n_tx_o_cnt;

    // ------------------------------------------------------------------
    // Writeback compare, first mismatch wins

    always_comb begin
        flt_now = FLT_NONE;
        if (dut_out_valid || grm_out_valid) begin
            if (dut_out_valid != grm_out_valid) begin
                flt_now = FLT_VALID;
            end else if (dut_result != grm_result) begin
                flt_now = FLT_RESULT;
            end else if (dut_rd_wen != grm_rd_wen) begin
                flt_now = FLT_WEN;
            end else if (grm_rd_wen && dut_rd_addr != grm_rd_addr) begin
                flt_now = FLT_RD_ADDR;
            end else if (grm_rd_wen && dut_rd_data != grm_rd_data) begin
                flt_now = FLT_RD_DATA;
            end
        end
        if (flt_now == FLT_NONE && outstanding > `COP_PIPE_DEPTH) begin
            flt_now = FLT_TXCOUNT;  // Something got lost or duplicated
        end
    end

    always_ff @(posedge g_clk) begin
        if (g_resetn) begin
            tx_i_cnt   <= '0;
            tx_o_cnt   <= '0;
            fault      <= 1'b0;
            fault_code <= FLT_NONE;
        end else begin
            tx_i_cnt <= n_tx_i_cnt;
            tx_o_cnt <= n_tx_o_cnt;
            if (!fault && flt_now != FLT_NONE) begin
                fault      <= 1'b1;
                fault_code <= flt_now;  // Held until reset
            end
        end
    end

endmodule

// ==== design/cop_lockstep_top.sv ====
`timescale 1ns/100ps
`include "cop_params.svh"

module cop_lockstep_top (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic                       in_valid,
    input  logic [31:0]                insn_enc,
    input  logic [`COP_XLEN-1:0]       rs1,
    output logic                       out_valid,
    output cop_isa_pkg::cop_result_t   result,
    output logic                       rd_wen,
    output logic [`COP_RADDR_W-1:0]    rd_addr,
    output logic [`COP_XLEN-1:0]       rd_data,
    output logic                       clk_req,
    output logic                       fault,
    output cop_check_pkg::cop_fault_t  fault_code
);

    import cop_isa_pkg::*;
    import cop_check_pkg::*;

    // Decode to execute
    logic                     dec_valid;
    cop_op_t                  dec_op;
    cop_result_t              dec_result;
    logic [SHAMT_W-1:0]       dec_shamt;
    logic [`COP_RADDR_W-1:0]  dec_rd;
    logic [`COP_XLEN-1:0]     dec_rs1;

    // Execute to result
    logic                     ex_valid;
    cop_result_t              ex_result;
    logic [`COP_RADDR_W-1:0]  ex_rd;
    logic [`COP_XLEN-1:0]     ex_data;

    // GRM to checker
    logic                     grm_out_valid;
    cop_result_t              grm_result;
    logic                     grm_rd_wen;
    logic [`COP_RADDR_W-1:0]  grm_rd_addr;
    logic [`COP_XLEN-1:0]     grm_rd_data;

    // ------------------------------------------------------------------
    // DUT pipeline

    cop_decode i_cop_decode (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .in_valid   (in_valid),
        .insn_enc   (insn_enc),
        .rs1        (rs1),
        .dec_valid  (dec_valid),
        .dec_op     (dec_op),
        .dec_result (dec_result),
        .dec_shamt  (dec_shamt),
        .dec_rd     (dec_rd),
        .dec_rs1    (dec_rs1)
    );

    cop_execute i_cop_execute (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .dec_valid  (dec_valid),
        .dec_op     (dec_op),
        .dec_result (dec_result),
        .dec_shamt  (dec_shamt),
        .dec_rd     (dec_rd),
        .dec_rs1    (dec_rs1),
        .ex_valid   (ex_valid),
        .ex_result  (ex_result),
        .ex_rd      (ex_rd),
        .ex_data    (ex_data)
    );

    cop_result i_cop_result (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .in_valid   (in_valid),
        .dec_valid  (dec_valid),
        .ex_valid   (ex_valid),
        .ex_result  (ex_result),
        .ex_rd      (ex_rd),
        .ex_data    (ex_data),
        .out_valid  (out_valid),
        .result     (result),
        .rd_wen     (rd_wen),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .clk_req    (clk_req)
    );

    // ------------------------------------------------------------------
    // Reference and compare

    cop_grm i_cop_grm (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .in_valid      (in_valid),      // Same stream as the DUT
        .insn_enc      (insn_enc),
        .rs1           (rs1),
        .grm_out_valid (grm_out_valid),
        .grm_result    (grm_result),
        .grm_rd_wen    (grm_rd_wen),
        .grm_rd_addr   (grm_rd_addr),
        .grm_rd_data   (grm_rd_data)
    );

    cop_lockstep_check i_cop_lockstep_check (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .dut_in_valid  (in_valid),
        .dut_out_valid (out_valid),
        .dut_result    (result),
        .dut_rd_wen    (rd_wen),
        .dut_rd_addr   (rd_addr),
        .dut_rd_data   (rd_data),
        .grm_out_valid (grm_out_valid),
        .grm_result    (grm_result),
        .grm_rd_wen    (grm_rd_wen),
        .grm_rd_addr   (grm_rd_addr),
        .grm_rd_data   (grm_rd_data),
        .fault         (fault),
        .fault_code    (fault_code)
    );

endmodule

// ==== design/cop_params.svh ====
`ifndef COP_PARAMS_SVH
`define COP_PARAMS_SVH

// ----------------------------------------------------------------------
// Datapath sizing

`define COP_XLEN        32  // GPR data width
`define COP_RADDR_W     5   // GPR index width

// ----------------------------------------------------------------------
// Timing and checking

`define COP_PIPE_DEPTH  3   // Decode, execute, result
`define COP_TXCNT_W     11  // Lockstep transaction counters

`endif

// ==== design/cop_result.sv ====
`timescale 1ns/100ps
`include "cop_params.svh"

module cop_result (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      in_valid,   // Only for clk_req
    input  logic                      dec_valid,  // Only for clk_req
    input  logic                      ex_valid,
    input  cop_isa_pkg::cop_result_t  ex_result,
    input  logic [`COP_RADDR_W-1:0]   ex_rd,
    input  logic [`COP_XLEN-1:0]      ex_data,
    output logic                      out_valid,
    output cop_isa_pkg::cop_result_t  result,
    output logic                      rd_wen,
    output logic [`COP_RADDR_W-1:0]   rd_addr,
    output logic [`COP_XLEN-1:0]      rd_data,
    output logic                      clk_req
);

    import cop_isa_pkg::*;

    logic wen_d;

    // No write on an illegal insn or to x0
    assign wen_d = ex_valid && (ex_result == RES_OK) && (ex_rd != '0);

    always_ff @(posedge g_clk) begin
        if (g_resetn) begin
            out_valid <= 1'b0;
            rd_wen    <= 1'b0;
        end else begin
            out_valid <= ex_valid;
            rd_wen    <= wen_d;
        end
    end

    always_ff @(posedge g_clk) begin
        result  <= ex_result;
        rd_addr <= ex_rd;                      // Always carries rd
        rd_data <= wen_d ? ex_data : '0;       // Zero whenever no write
    end

    // Any stage busy keeps the clock running
    assign clk_req = in_valid | dec_valid | ex_valid | out_valid;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the lockstep testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f all.f \
    --top-module tb_cop_lockstep \
    --Mdir obj_dir

./obj_dir/Vtb_cop_lockstep | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== tests/tb_cop_lockstep.sv ====
`timescale 1ns/100ps
`include "cop_params.svh"

module tb_cop_lockstep;

    import cop_isa_pkg::*;
    import cop_check_pkg::*;

    localparam logic [6:0] CUSTOM0    = 7'b0001011;  // custom-0 major opcode
    localparam int         LATENCY    = 3;           // Input edge to out_valid
    localparam int         WAIT_LIMIT = 200;         // Cycles per wait loop

    // Expected writeback of one instruction
    typedef struct packed {
        cop_result_t              res;
        logic                     wen;
        logic [`COP_RADDR_W-1:0]  addr;
        logic [`COP_XLEN-1:0]     data;
    } wb_t;

    logic                     g_clk;
    logic                     g_resetn;
    logic                     in_valid;
    logic [31:0]              insn_enc;
    logic [`COP_XLEN-1:0]     rs1;
    logic                     out_valid;
    cop_result_t              result;
    logic                     rd_wen;
    logic [`COP_RADDR_W-1:0]  rd_addr;
    logic [`COP_XLEN-1:0]     rd_data;
    logic                     clk_req;
    logic                     fault;
    cop_fault_t               fault_code;

    wb_t          exp_q[$];   // Model output in issue order
    int           due_q[$];   // Negedge index where each output is due
    int           neg_cnt;
    logic [31:0]  rng;

    cop_lockstep_top i_cop_lockstep_top (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .in_valid   (in_valid),
        .insn_enc   (insn_enc),
        .rs1        (rs1),
        .out_valid  (out_valid),
        .result     (result),
        .rd_wen     (rd_wen),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .clk_req    (clk_req),
        .fault      (fault),
        .fault_code (fault_code)
    );

    always #50 g_clk = ~g_clk;  // 100 ns period

    // ------------------------------------------------------------------
    // Reference model

    function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = x[(i + n) % 32];
        end
        return r;
    endfunction

    function automatic logic [31:0] byte_swap(input logic [31:0] x);
        return {x[7:0], x[15:8], x[23:16], x[31:24]};
    endfunction

    function automatic logic [31:0] mirror_bytes(input logic [31:0] x);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = x[8 * (i / 8) + 7 - (i % 8)];  // Bit 0 swaps with bit 7 etc
        end
        return r;
    endfunction

    function automatic wb_t model_wb(input logic [31:0] insn, input logic [31:0] x);
        wb_t         w;
        logic [31:0] v;
        v = '0;
        if (insn[6:0] != CUSTOM0) begin
            w.res = RES_BAD_OPCODE;
        end else if (insn[31:25] != 7'd0 || insn[14:12] == 3'd7) begin
            w.res = RES_BAD_FUNCT;
        end else begin
            w.res = RES_OK;
            case (insn[14:12])
                3'd0: v = rotr(x, int'(insn[24:20]));
                3'd1: v = byte_swap(x);
                3'd2: v = mirror_bytes(x);
                3'd3: v = rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);    // sig0
                3'd4: v = rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);  // sig1
                3'd5: v = rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22); // sum0
                default: v = rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
            endcase
        end
        w.addr = insn[11:7];
        w.wen  = (w.res == RES_OK) && (w.addr != '0);  // x0 never written
        w.data = w.wen ? v : '0;
        return w;
    endfunction

    function automatic logic [31:0] make_insn(input logic [6:0] f7, input logic [4:0] shamt,
                                              input logic [4:0] src, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [6:0] opc);
        return {f7, shamt, src, f3, rd, opc};
    endfunction

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // ------------------------------------------------------------------
    // Compare tasks

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_result(input cop_result_t got, input cop_result_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("ERR %0t ns: result %0d, expected %s",
                                      $time, got, exp.name()));
        end
    endtask

    task automatic check_data(input logic got_wen, input logic [`COP_RADDR_W-1:0] got_addr,
                              input logic [`COP_XLEN-1:0] got_data, input wb_t exp);
        check_bit(got_wen, exp.wen, "rd_wen");
        if (got_addr !== exp.addr) begin
            stop_with_error($sformatf("ERR %0t ns: rd_addr %0d, expected %0d",
                                      $time, got_addr, exp.addr));
        end
        if (got_data !== exp.data) begin
            stop_with_error($sformatf("ERR %0t ns: rd_data %h, expected %h",
                                      $time, got_data, exp.data));
        end
    endtask

    task automatic check_fault(input logic got_flag, input cop_fault_t got_code,
                               input cop_fault_t exp_code);
        check_bit(got_flag, exp_code != FLT_NONE, "fault");
        if (got_code !== exp_code) begin
            stop_with_error($sformatf("ERR %0t ns: fault_code %0d, expected %s",
                                      $time, got_code, exp_code.name()));
        end
    endtask

    // ------------------------------------------------------------------
    // Monitor on the falling edge

    always @(negedge g_clk) begin : monitor
        wb_t exp;
        neg_cnt++;
        if (!g_resetn) begin  // Out of reset
            check_fault(fault, fault_code, FLT_NONE);
            if (due_q.size() > 0 && due_q[0] == neg_cnt && !out_valid) begin
                stop_with_error("out_valid did not rise 3 cycles after the instruction");
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("out_valid rose with no instruction outstanding");
                end
                if (due_q[0] != neg_cnt) begin
                    stop_with_error($sformatf("ERR %0t ns: out_valid %0d cycles early",
                                              $time, due_q[0] - neg_cnt));
                end
                exp = exp_q.pop_front();
                void'(due_q.pop_front());
                check_result(result, exp.res);
                check_data(rd_wen, rd_addr, rd_data, exp);
            end
        end
    end

    // ------------------------------------------------------------------
    // Drivers

    task automatic send_insn(input logic [31:0] insn, input logic [31:0] val);
        @(posedge g_clk);
        in_valid <= 1'b1;
        insn_enc <= insn;
        rs1      <= val;
        exp_q.push_back(model_wb(insn, val));
        due_q.push_back(neg_cnt + LATENCY + 1);  // Taken next edge and seen a negedge later
    endtask

    task automatic drive_idle();
        @(posedge g_clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge g_clk);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_with_error("timed out waiting for outstanding writebacks");
            end
        end
    endtask

    task automatic run_one(input logic [31:0] insn, input logic [31:0] val);
        send_insn(insn, val);
        drive_idle();
        wait_drain();
    endtask

    // ------------------------------------------------------------------
    // Directed tests

    task automatic test_reset_state();
        repeat (2) @(negedge g_clk);
        check_bit(out_valid, 1'b0, "out_valid");
        check_bit(rd_wen, 1'b0, "rd_wen");
        check_bit(clk_req, 1'b0, "clk_req");
        check_fault(fault, fault_code, FLT_NONE);
    endtask

    task automatic test_ror();
        int amt[5] = '{0, 1, 8, 13, 31};
        foreach (amt[i]) begin
            run_one(make_insn(7'd0, amt[i][4:0], 5'd3, 3'd0, 5'd5, CUSTOM0), 32'h8000_0001);
            run_one(make_insn(7'd0, amt[i][4:0], 5'd4, 3'd0, 5'd9, CUSTOM0), next_rand());
        end
    endtask

    task automatic test_bit_perm();
        run_one(make_insn(7'd0, 5'd0, 5'd1, 3'd1, 5'd7, CUSTOM0), 32'h0123_4567);  // rev8
        run_one(make_insn(7'd0, 5'd0, 5'd1, 3'd1, 5'd7, CUSTOM0), 32'hA5C3_0F81);
        run_one(make_insn(7'd0, 5'd0, 5'd2, 3'd2, 5'd8, CUSTOM0), 32'h0123_4567);  // brev8
        run_one(make_insn(7'd0, 5'd0, 5'd2, 3'd2, 5'd8, CUSTOM0), 32'hA5C3_0F81);
    endtask

    task automatic test_sha();
        for (int f = 3; f <= 6; f++) begin
            repeat (3) run_one(make_insn(7'd0, 5'd0, 5'd6, f[2:0], 5'd12, CUSTOM0), next_rand());
        end
    endtask

    task automatic test_illegal();
        run_one(make_insn(7'd0, 5'd0, 5'd1, 3'd1, 5'd3, 7'b0110011), 32'hDEAD_BEEF);
        run_one(make_insn(7'd1, 5'd0, 5'd1, 3'd0, 5'd3, CUSTOM0), 32'hDEAD_BEEF);   // funct7
        run_one(make_insn(7'd0, 5'd0, 5'd1, 3'd7, 5'd3, CUSTOM0), 32'hDEAD_BEEF);   // funct3 7
        run_one(make_insn(7'd0, 5'd4, 5'd1, 3'd0, 5'd0, CUSTOM0), 32'hDEAD_BEEF);   // rd x0
    endtask

    task automatic test_burst();
        logic [31:0] r;
        logic [6:0]  opc;
        for (int i = 0; i < 50; i++) begin
            r   = next_rand();
            opc = (r[2:0] == 3'd0) ? (r[30:24] ^ 7'b1000000) : CUSTOM0;  // 1 in 8 bad opcode
            if (opc == CUSTOM0 && r[2:0] == 3'd0) begin
                opc = 7'b1111111;
            end
            send_insn(make_insn((r[5:3] == 3'd0) ? 7'd2 : 7'd0, r[18:14], r[23:19], r[8:6],
                                r[13:9], opc), next_rand());
        end
        drive_idle();
        wait_drain();
    endtask

    task automatic test_clk_req();
        int n;
        n = 0;
        send_insn(make_insn(7'd0, 5'd0, 5'd1, 3'd5, 5'd2, CUSTOM0), next_rand());
        @(negedge g_clk);
        check_bit(clk_req, 1'b1, "clk_req with in_valid");  // Pipeline still empty here
        drive_idle();
        do begin
            @(negedge g_clk);
            check_bit(clk_req, 1'b1, "clk_req in flight");
            n++;
            if (n > WAIT_LIMIT) begin
                stop_with_error("timed out waiting for out_valid in the clk_req test");
            end
        end while (!out_valid);
        @(negedge g_clk);
        check_bit(clk_req, 1'b0, "clk_req after drain");  // Pipeline now empty
    endtask

    // ------------------------------------------------------------------
    // Sequence

    initial begin
        g_clk    = 1'b0;
        g_resetn = 1'b1;  // Reset is active high
        in_valid = 1'b0;
        insn_enc = '0;
        rs1      = '0;
        neg_cnt  = 0;
        rng      = 32'd57132;
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b0;

        test_reset_state();
        test_ror();
        test_bit_perm();
        test_sha();
        test_illegal();
        test_burst();
        test_clk_req();

        repeat (2) @(negedge g_clk);
        check_fault(fault, fault_code, FLT_NONE);  // No lockstep mismatch all run
        $display("** PASS **");
        $finish;
    end

endmodule
